/* verilog/btb_pkg.sv */
package btb_pkg;

    // ------------------------------------------------------------
    // geometry

    // halfword instruction slots per fetch block
    localparam int BTB_SLOTS = 8;
    localparam int BTB_SLOT_WIDTH = 3;

    localparam int BTB_SETS = 64;
    localparam int BTB_INDEX_WIDTH = 6;

    // ------------------------------------------------------------
    // field widths

    localparam int BTB_TAG_WIDTH = 10;
    localparam int BTB_PRED_INFO_WIDTH = 8;
    localparam int BTB_TARGET_WIDTH = 32;
    localparam int BTB_ASID_WIDTH = 9;

    // pc bit positions, halfword aligned
    localparam int BTB_SLOT_LSB = 1;
    localparam int BTB_INDEX_LSB = BTB_SLOT_LSB + BTB_SLOT_WIDTH;
    localparam int BTB_TAG_LSB = BTB_INDEX_LSB + BTB_INDEX_WIDTH;

    // ------------------------------------------------------------
    // types

    typedef logic [31:0] pc_t;
    typedef logic [BTB_ASID_WIDTH-1:0] asid_t;

    typedef logic [BTB_INDEX_WIDTH-1:0] btb_index_t;
    typedef logic [BTB_SLOT_WIDTH-1:0] btb_slot_t;
    typedef logic [BTB_TAG_WIDTH-1:0] btb_tag_t;

    typedef logic [BTB_PRED_INFO_WIDTH-1:0] pred_info_t;
    typedef logic [BTB_TARGET_WIDTH-1:0] btb_target_t;

    // one bit per instruction slot
    typedef logic [BTB_SLOTS-1:0] slot_mask_t;

endpackage

/* verilog/btb_way_if.sv */
`timescale 1ns/1ps

// one way's set row as seen after the registered read
interface btb_way_if;

    import btb_pkg::*;

    // per-slot valid bits
    slot_mask_t valid;

    // per-slot stored fields
    btb_tag_t [BTB_SLOTS-1:0] tag;
    pred_info_t [BTB_SLOTS-1:0] pred_info;
    btb_target_t [BTB_SLOTS-1:0] target;

    // storage side
    modport bank (
        output valid,
        output tag,
        output pred_info,
        output target
    );

    // compare / select side
    modport sel (
        input valid,
        input tag,
        input pred_info,
        input target
    );

endinterface

/* verilog/btb_tag_hash.sv */
`timescale 1ns/1ps

module btb_tag_hash (
    input btb_pkg::pc_t pc,
    input btb_pkg::asid_t asid,
    output btb_pkg::btb_tag_t tag
);

    import btb_pkg::*;

    btb_tag_t pc_low_field;
    btb_tag_t pc_high_field;
    btb_tag_t asid_field;

    // two pc fields right above the set index
    assign pc_low_field = pc[BTB_TAG_LSB +: BTB_TAG_WIDTH];
    assign pc_high_field = pc[BTB_TAG_LSB+BTB_TAG_WIDTH +: BTB_TAG_WIDTH];

    // asid is one bit narrower than the tag
    assign asid_field = BTB_TAG_WIDTH'(asid);

    // fold everything together
    assign tag = pc_low_field ^ pc_high_field ^ asid_field;

endmodule

/* verilog/btb_way_bank.sv */
`timescale 1ns/1ps

module btb_way_bank (
    input logic CLK,
    input logic nRST,

    // read port
    input logic ren,
    input btb_pkg::btb_index_t rindex,
    btb_way_if.bank rd,

    // write port
    input logic wen,
    input btb_pkg::btb_index_t windex,
    input btb_pkg::btb_slot_t wslot,
    input btb_pkg::btb_tag_t wtag,
    input btb_pkg::pred_info_t wpred_info,
    input btb_pkg::btb_target_t wtarget
);

    import btb_pkg::*;

    // ------------------------------------------------------------
    // storage

    btb_tag_t [BTB_SLOTS-1:0] tag_mem [BTB_SETS];
    pred_info_t [BTB_SLOTS-1:0] pred_info_mem [BTB_SETS];
    btb_target_t [BTB_SLOTS-1:0] target_mem [BTB_SETS];

    // one valid bit per set and slot
    slot_mask_t [BTB_SETS-1:0] valid_mem;

    // ------------------------------------------------------------
    // write port

    always_ff @(posedge CLK) begin
        if (wen) begin
            tag_mem[windex][wslot] <= wtag;
            pred_info_mem[windex][wslot] <= wpred_info;
            target_mem[windex][wslot] <= wtarget;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            valid_mem <= '0;
        end else if (wen) begin
            valid_mem[windex][wslot] <= 1'b1;
        end
    end

    // ------------------------------------------------------------
    // read port, whole set row
    // a same-cycle write to this set is not seen here

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            rd.valid <= '0;
        end else if (ren) begin
            rd.valid <= valid_mem[rindex];
        end
    end

    always_ff @(posedge CLK) begin
        if (ren) begin
            rd.tag <= tag_mem[rindex];
            rd.pred_info <= pred_info_mem[rindex];
            rd.target <= target_mem[rindex];
        end
    end

endmodule

/* verilog/btb_update_ctrl.sv */
`timescale 1ns/1ps

module btb_update_ctrl (
    // update request
    input logic update_valid,
    input btb_pkg::pc_t update_pc,
    input btb_pkg::asid_t update_asid,
    input btb_pkg::pred_info_t update_pred_info,
    input logic update_pred_lru,
    input btb_pkg::btb_target_t update_target,

    // way bank writes
    output logic wen0,
    output logic wen1,
    output btb_pkg::btb_index_t windex,
    output btb_pkg::btb_slot_t wslot,
    output btb_pkg::btb_tag_t wtag,
    output btb_pkg::pred_info_t wpred_info,
    output btb_pkg::btb_target_t wtarget,

    // lru write
    output logic lru_wen,
    output logic lru_value
);

    import btb_pkg::*;

    // split the pc into set and slot
    assign windex = update_pc[BTB_INDEX_LSB +: BTB_INDEX_WIDTH];
    assign wslot = update_pc[BTB_SLOT_LSB +: BTB_SLOT_WIDTH];

    // same hash as the lookup side
    btb_tag_hash update_hash (
        .pc(update_pc),
        .asid(update_asid),
        .tag(wtag)
    );

    assign wpred_info = update_pred_info;
    assign wtarget = update_target;

    // lru bit names the way to replace
    assign wen0 = update_valid & ~update_pred_lru;
    assign wen1 = update_valid & update_pred_lru;

    // next victim is the other way
    assign lru_wen = update_valid;
    assign lru_value = ~update_pred_lru;

endmodule

/* verilog/btb_way_select.sv */
`timescale 1ns/1ps

module btb_way_select (
    input logic CLK,
    input logic nRST,

    // lookup request
    input logic valid_req,
    input btb_pkg::btb_index_t rindex,
    input btb_pkg::btb_tag_t tag_req,

    // registered way rows
    btb_way_if.sel way0,
    btb_way_if.sel way1,

    // lru write
    input logic lru_wen,
    input btb_pkg::btb_index_t windex,
    input btb_pkg::btb_slot_t wslot,
    input logic lru_value,

    // response
    output logic resp_valid,
    output btb_pkg::slot_mask_t hit,
    output btb_pkg::pred_info_t [btb_pkg::BTB_SLOTS-1:0] pred_info,
    output btb_pkg::slot_mask_t lru,
    output btb_pkg::btb_target_t [btb_pkg::BTB_SLOTS-1:0] target
);

    import btb_pkg::*;

    slot_mask_t [BTB_SETS-1:0] lru_mem;
    slot_mask_t lru_row;
    btb_tag_t tag_resp;
    slot_mask_t match0;
    slot_mask_t match1;

    // ------------------------------------------------------------
    // lru memory and request registers

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            lru_mem <= '0;
            lru_row <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= valid_req;
            // read sees the old row on a same-set write
            if (valid_req) begin
                lru_row <= lru_mem[rindex];
            end
            if (lru_wen) begin
                lru_mem[windex][wslot] <= lru_value;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (valid_req) begin
            tag_resp <= tag_req;
        end
    end

    // ------------------------------------------------------------
    // per-slot compare and select

    always_comb begin
        for (int i = 0; i < BTB_SLOTS; i++) begin
            match0[i] = way0.valid[i] && (way0.tag[i] == tag_resp);
            match1[i] = way1.valid[i] && (way1.tag[i] == tag_resp);
            hit[i] = match0[i] | match1[i];

            if (match0[i]) begin
                // way 0 wins ties
                pred_info[i] = way0.pred_info[i];
                target[i] = way0.target[i];
                lru[i] = 1'b0;
            end else if (match1[i]) begin
                pred_info[i] = way1.pred_info[i];
                target[i] = way1.target[i];
                lru[i] = 1'b1;
            end else begin
                // miss, way 0 fields and stored victim
                pred_info[i] = way0.pred_info[i];
                target[i] = way0.target[i];
                lru[i] = lru_row[i];
            end
        end
    end

endmodule

/* verilog/btb.sv */
`timescale 1ns/1ps

module btb (
    input logic CLK,
    input logic nRST,

    // lookup request
    input logic valid_req,
    input btb_pkg::pc_t pc_req,
    input btb_pkg::asid_t asid_req,

    // lookup response, one cycle later
    output logic resp_valid,
    output btb_pkg::slot_mask_t resp_hit,
    output btb_pkg::pred_info_t [btb_pkg::BTB_SLOTS-1:0] resp_pred_info,
    output btb_pkg::slot_mask_t resp_lru,
    output btb_pkg::btb_target_t [btb_pkg::BTB_SLOTS-1:0] resp_target,

    // update
    input logic update_valid,
    input btb_pkg::pc_t update_pc,
    input btb_pkg::asid_t update_asid,
    input btb_pkg::pred_info_t update_pred_info,
    input logic update_pred_lru,
    input btb_pkg::btb_target_t update_target
);

    import btb_pkg::*;

    // ------------------------------------------------------------
    // wires

    btb_index_t index_req;
    btb_tag_t tag_req;

    logic wen0;
    logic wen1;
    btb_index_t windex;
    btb_slot_t wslot;
    btb_tag_t wtag;
    pred_info_t wpred_info;
    btb_target_t wtarget;
    logic lru_wen;
    logic lru_value;

    btb_way_if way0_rd ();
    btb_way_if way1_rd ();

    assign index_req = pc_req[BTB_INDEX_LSB +: BTB_INDEX_WIDTH];

    // ------------------------------------------------------------
    // lookup side

    btb_tag_hash req_hash (
        .pc(pc_req),
        .asid(asid_req),
        .tag(tag_req)
    );

    btb_way_bank way0_bank (
        .CLK(CLK), .nRST(nRST),
        .ren(valid_req), .rindex(index_req), .rd(way0_rd.bank),
        .wen(wen0), .windex(windex), .wslot(wslot),
        .wtag(wtag), .wpred_info(wpred_info), .wtarget(wtarget)
    );

    btb_way_bank way1_bank (
        .CLK(CLK), .nRST(nRST),
        .ren(valid_req), .rindex(index_req), .rd(way1_rd.bank),
        .wen(wen1), .windex(windex), .wslot(wslot),
        .wtag(wtag), .wpred_info(wpred_info), .wtarget(wtarget)
    );

    btb_way_select way_sel (
        .CLK(CLK), .nRST(nRST),
        .valid_req(valid_req), .rindex(index_req), .tag_req(tag_req),
        .way0(way0_rd.sel), .way1(way1_rd.sel),
        .lru_wen(lru_wen), .windex(windex), .wslot(wslot), .lru_value(lru_value),
        .resp_valid(resp_valid), .hit(resp_hit), .pred_info(resp_pred_info),
        .lru(resp_lru), .target(resp_target)
    );

    // ------------------------------------------------------------
    // update side

    btb_update_ctrl upd_ctrl (
        .update_valid(update_valid), .update_pc(update_pc),
        .update_asid(update_asid), .update_pred_info(update_pred_info),
        .update_pred_lru(update_pred_lru), .update_target(update_target),
        .wen0(wen0), .wen1(wen1), .windex(windex), .wslot(wslot),
        .wtag(wtag), .wpred_info(wpred_info), .wtarget(wtarget),
        .lru_wen(lru_wen), .lru_value(lru_value)
    );

endmodule

/* test/btb_tb.sv */
`timescale 1ns/1ps

module btb_tb;

    import btb_pkg::*;

    logic CLK;
    logic nRST;
    logic valid_req;
    pc_t pc_req;
    asid_t asid_req;
    logic resp_valid;
    slot_mask_t resp_hit;
    pred_info_t [BTB_SLOTS-1:0] resp_pred_info;
    slot_mask_t resp_lru;
    btb_target_t [BTB_SLOTS-1:0] resp_target;
    logic update_valid;
    pc_t update_pc;
    asid_t update_asid;
    pred_info_t update_pred_info;
    logic update_pred_lru;
    btb_target_t update_target;

    integer seed = 76;
    int error_count = 0;
    int check_count = 0;

    // reference model, keyed by set, way and slot
    btb_tag_t ref_tag [int];
    pred_info_t ref_pred [int];
    btb_target_t ref_target [int];
    slot_mask_t ref_lru [BTB_SETS];

    // expected response of the pending lookup
    slot_mask_t exp_hit;
    slot_mask_t exp_lru;
    slot_mask_t exp_fields;
    pred_info_t exp_pred [BTB_SLOTS];
    btb_target_t exp_target [BTB_SLOTS];

    btb dut0 (
        .CLK(CLK), .nRST(nRST),
        .valid_req(valid_req), .pc_req(pc_req), .asid_req(asid_req),
        .resp_valid(resp_valid), .resp_hit(resp_hit), .resp_pred_info(resp_pred_info),
        .resp_lru(resp_lru), .resp_target(resp_target),
        .update_valid(update_valid), .update_pc(update_pc), .update_asid(update_asid),
        .update_pred_info(update_pred_info), .update_pred_lru(update_pred_lru),
        .update_target(update_target)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // ------------------------------------------------------------
    // reference model

    function automatic btb_tag_t hash_tag(pc_t pc, asid_t asid);
        return pc[19:10] ^ pc[29:20] ^ {1'b0, asid};
    endfunction

    function automatic int entry_key(pc_t pc, int way, int slot);
        return pc[9:4] * 16 + way * 8 + slot;
    endfunction

    // small pool of sets and tags so that hits are common
    function automatic pc_t random_pc();
        pc_t pc;
        pc = $random(seed);
        pc[31:12] = '0;
        pc[9:6] = '0;
        pc[0] = 1'b0;
        return pc;
    endfunction

    // victim of the written slot becomes the other way
    task automatic write_model(pc_t pc, asid_t asid, pred_info_t pred, logic way,
                               btb_target_t tgt);
        int key;
        key = entry_key(pc, way, pc[3:1]);
        ref_tag[key] = hash_tag(pc, asid);
        ref_pred[key] = pred;
        ref_target[key] = tgt;
        ref_lru[pc[9:4]][pc[3:1]] = ~way;
    endtask

    task automatic predict_response(pc_t pc, asid_t asid);
        int key0;
        int key1;
        btb_tag_t tag;
        tag = hash_tag(pc, asid);
        for (int i = 0; i < BTB_SLOTS; i++) begin
            key0 = entry_key(pc, 0, i);
            key1 = entry_key(pc, 1, i);
            exp_fields[i] = 1'b0;
            exp_pred[i] = '0;
            exp_target[i] = '0;
            if (ref_tag.exists(key0) && ref_tag[key0] == tag) begin
                exp_hit[i] = 1'b1;
                exp_lru[i] = 1'b0;
                exp_fields[i] = 1'b1;
                exp_pred[i] = ref_pred[key0];
                exp_target[i] = ref_target[key0];
            end else if (ref_tag.exists(key1) && ref_tag[key1] == tag) begin
                exp_hit[i] = 1'b1;
                exp_lru[i] = 1'b1;
                exp_fields[i] = 1'b1;
                exp_pred[i] = ref_pred[key1];
                exp_target[i] = ref_target[key1];
            end else begin
                exp_hit[i] = 1'b0;
                exp_lru[i] = ref_lru[pc[9:4]][i];
                // a miss shows way 0's fields where way 0 holds the slot
                if (ref_tag.exists(key0)) begin
                    exp_fields[i] = 1'b1;
                    exp_pred[i] = ref_pred[key0];
                    exp_target[i] = ref_target[key0];
                end
            end
        end
    endtask

    // ------------------------------------------------------------
    // driving and checking

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_response();
        compare_value("resp_valid", 1, resp_valid);
        compare_value("resp_hit", exp_hit, resp_hit);
        compare_value("resp_lru", exp_lru, resp_lru);
        // fields are unknown where way 0 never held the slot and nothing hit
        for (int i = 0; i < BTB_SLOTS; i++) begin
            if (exp_fields[i]) begin
                compare_value($sformatf("resp_pred_info[%0d]", i), exp_pred[i],
                              resp_pred_info[i]);
                compare_value($sformatf("resp_target[%0d]", i), exp_target[i],
                              resp_target[i]);
            end
        end
    endtask

    task automatic drive_update(pc_t pc, asid_t asid, pred_info_t pred, logic way,
                                btb_target_t tgt);
        update_valid = 1'b1;
        update_pc = pc;
        update_asid = asid;
        update_pred_info = pred;
        update_pred_lru = way;
        update_target = tgt;
        write_model(pc, asid, pred, way, tgt);
    endtask

    task automatic single_update(pc_t pc, asid_t asid, logic way);
        drive_update(pc, asid, $random(seed), way, $random(seed));
        next_cycle();
        update_valid = 1'b0;
    endtask

    task automatic lookup(pc_t pc, asid_t asid);
        int waited;
        predict_response(pc, asid);
        valid_req = 1'b1;
        pc_req = pc;
        asid_req = asid;
        next_cycle();
        valid_req = 1'b0;
        waited = 0;
        while (!resp_valid && waited < 20) begin
            next_cycle();
            waited++;
        end
        if (!resp_valid) begin
            error_count++;
            $display("no lookup response within 20 cycles at %0t", $time);
        end else begin
            check_response();
        end
    endtask

    task automatic report_test(string name, int errors_before);
        $display("%s finished with %0d errors", name, error_count - errors_before);
    endtask

    // ------------------------------------------------------------
    // tests

    task automatic check_after_reset();
        int errors_before;
        errors_before = error_count;
        repeat (3) begin
            compare_value("resp_valid", 0, resp_valid);
            next_cycle();
        end
        repeat (4) lookup($random(seed), $random(seed));
        report_test("after reset", errors_before);
    endtask

    task automatic basic_update_lookup();
        int errors_before;
        pc_t pc;
        asid_t asid;
        errors_before = error_count;
        pc = $random(seed);
        asid = $random(seed);
        single_update(pc, asid, 1'b0);
        lookup(pc, asid);
        // other asid, other tag
        lookup(pc, asid ^ 9'h1);
        report_test("basic update and lookup", errors_before);
    endtask

    task automatic way0_priority();
        int errors_before;
        pc_t pc;
        pc_t fresh_pc;
        asid_t asid;
        errors_before = error_count;
        pc = $random(seed);
        pc[9:4] = 6'd20;
        pc[3:1] = 3'd2;
        asid = $random(seed);
        single_update(pc, asid, 1'b1);
        single_update(pc, asid, 1'b0);
        lookup(pc, asid);
        fresh_pc = pc;
        fresh_pc[3:1] = 3'd5;
        single_update(fresh_pc, asid, 1'b1);
        lookup(fresh_pc, asid);
        report_test("way 0 priority", errors_before);
    endtask

    task automatic lru_on_miss();
        int errors_before;
        pc_t pc;
        asid_t asid;
        errors_before = error_count;
        pc = $random(seed);
        pc[9:4] = 6'd33;
        pc[3:1] = 3'd4;
        asid = $random(seed);
        single_update(pc, asid, 1'b0);
        // flipping pc bit 10 changes the tag, same set and slot
        lookup(pc ^ 32'h400, asid);
        report_test("lru on miss", errors_before);
    endtask

    task automatic random_traffic();
        int errors_before;
        pc_t lookup_pc;
        asid_t lookup_asid;
        errors_before = error_count;
        valid_req = 1'b1;
        repeat (40) begin
            lookup_pc = random_pc();
            lookup_asid = $random(seed) & 1;
            pc_req = lookup_pc;
            asid_req = lookup_asid;
            // predicted before this cycle's write, a same-set read sees old data
            predict_response(lookup_pc, lookup_asid);
            if (($random(seed) & 3) != 0) begin
                drive_update(random_pc(), $random(seed) & 1, $random(seed), $random(seed),
                             $random(seed));
            end else begin
                update_valid = 1'b0;
            end
            next_cycle();
            check_response();
        end
        valid_req = 1'b0;
        update_valid = 1'b0;
        report_test("random traffic", errors_before);
    endtask

    initial begin
        valid_req = 1'b0;
        pc_req = '0;
        asid_req = '0;
        update_valid = 1'b0;
        update_pc = '0;
        update_asid = '0;
        update_pred_info = '0;
        update_pred_lru = 1'b0;
        update_target = '0;
        nRST = 1'b0;
        for (int i = 0; i < BTB_SETS; i++) begin
            ref_lru[i] = '0;
        end
        repeat (16) @(posedge CLK);
        #1;
        nRST = 1'b1;

        check_after_reset();
        basic_update_lookup();
        way0_priority();
        lru_on_miss();
        random_traffic();

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* lorof_btb.f */
verilog/btb_pkg.sv
verilog/btb_way_if.sv
verilog/btb_tag_hash.sv
verilog/btb_way_bank.sv
verilog/btb_update_ctrl.sv
verilog/btb_way_select.sv
verilog/btb.sv
test/btb_tb.sv
